//--- hw/afe_dac_cfg.sv
`timescale 1ns/10ps

module afe_dac_cfg import dac_cfg_pkg::*; (
    input  logic      clk10,
    input  logic      resetS,

    // register write bus
    input  logic      io_sel,
    input  logic      io_sync,
    input  logic      io_wr_en,
    input  reg_addr_t io_addr,
    input  dac_word_t io_wr_data,

    // DAC chain
    output logic      sclk,
    output logic      sdi,
    output logic      sync_n,
    output logic      busy    // configuration in progress
);

    func_t     func_sel;
    dac_word_t func_words [NUM_DACS];
    logic      cfg_trigger;

    dac_frame_if frame_bus ();

    assign sclk = clk10;  // DACs clock on the system clock

    dac_cfg_regs i_dac_cfg_regs (
        .clk10       (clk10),
        .resetS      (resetS),
        .io_sel      (io_sel),
        .io_sync     (io_sync),
        .io_wr_en    (io_wr_en),
        .io_addr     (io_addr),
        .io_wr_data  (io_wr_data),
        .func_sel    (func_sel),
        .func_words  (func_words),
        .cfg_trigger (cfg_trigger)
    );

    dac_cfg_sequencer i_dac_cfg_sequencer (
        .clk10       (clk10),
        .resetS      (resetS),
        .cfg_trigger (cfg_trigger),
        .func_sel    (func_sel),
        .func_words  (func_words),
        .frame       (frame_bus.requester),
        .busy        (busy)
    );

    dac_frame_shifter i_dac_frame_shifter (
        .clk10       (clk10),
        .resetS      (resetS),
        .frame       (frame_bus.shifter),
        .sdi         (sdi),
        .sync_n      (sync_n)
    );

endmodule

//--- hw/dac_cfg_pkg.sv
package dac_cfg_pkg;

    // ========================================================================
    // widths and types
    // ========================================================================
    localparam int NUM_DACS   = 3;  // DACs in the daisy chain
    localparam int NUM_FUNCS  = 7;
    localparam int WORD_BITS  = 32;
    localparam int FRAME_BITS = NUM_DACS * WORD_BITS;
    localparam int NUM_STEPS  = 12;

    typedef logic [WORD_BITS-1:0]          dac_word_t;
    typedef logic [FRAME_BITS-1:0]         frame_data_t;
    typedef logic [4:0]                    reg_addr_t;
    typedef logic [2:0]                    func_t;
    typedef logic [1:0]                    dac_idx_t;
    typedef logic [1:0]                    word_cnt_t;  // 1 to 3 words per frame
    typedef logic [$clog2(FRAME_BITS)-1:0] bit_cnt_t;
    typedef logic [$clog2(NUM_STEPS)-1:0]  step_t;

    // function groups, data register address = 3 * func + dac index
    localparam func_t FUNC_MODE   = 3'd0;
    localparam func_t FUNC_LDAC   = 3'd1;
    localparam func_t FUNC_DCEN   = 3'd2;
    localparam func_t FUNC_CHAN_A = 3'd3;
    localparam func_t FUNC_CHAN_B = 3'd4;
    localparam func_t FUNC_CHAN_C = 3'd5;
    localparam func_t FUNC_CHAN_D = 3'd6;

    localparam reg_addr_t CTRL_ADDR = 5'd26;  // bit 0 rising edge starts a sequence

    // ========================================================================
    // programming sequence, chain grows one DAC at a time
    // ========================================================================
    localparam func_t SEQ_FUNC [NUM_STEPS] = '{
        FUNC_LDAC, FUNC_DCEN, FUNC_LDAC, FUNC_DCEN, FUNC_LDAC, FUNC_DCEN,
        FUNC_MODE, FUNC_CHAN_A, FUNC_CHAN_B, FUNC_CHAN_C, FUNC_CHAN_D, FUNC_MODE
    };

    localparam word_cnt_t SEQ_WORDS [NUM_STEPS] = '{
        2'd1, 2'd1, 2'd2, 2'd2, 2'd3, 2'd3, 2'd3, 2'd3, 2'd3, 2'd3, 2'd3, 2'd3
    };

    // power-on words, shared by all three DACs
    localparam dac_word_t DEF_WORD [NUM_FUNCS] = '{
        32'h0800_0001,  // internal reference on
        32'h0600_000F,  // LDAC mask, all channels update at once
        32'h0900_0001,  // daisy chain enable
        32'h0300_8000,  // channel A midscale
        32'h0310_8000,  // channel B midscale
        32'h0320_8000,  // channel C midscale
        32'h0330_8000   // channel D midscale
    };

    typedef enum logic [1:0] {SEQ_IDLE, SEQ_REQUEST, SEQ_WAIT_DONE} seq_state_t;
    typedef enum logic [1:0] {SH_IDLE, SH_SHIFT, SH_GAP} shift_state_t;

endpackage

//--- hw/dac_cfg_regs.sv
`timescale 1ns/10ps

module dac_cfg_regs import dac_cfg_pkg::*; (
    input  logic      clk10,
    input  logic      resetS,

    // register write bus
    input  logic      io_sel,
    input  logic      io_sync,
    input  logic      io_wr_en,
    input  reg_addr_t io_addr,
    input  dac_word_t io_wr_data,

    // to the sequencer
    input  func_t     func_sel,
    output dac_word_t func_words [NUM_DACS],
    output logic      cfg_trigger
);

    // ========================================================================
    // register storage
    // ========================================================================
    dac_word_t data_regs [NUM_FUNCS][NUM_DACS];  // [function][dac]
    logic      ctrl_go;    // control bit 0
    logic      ctrl_go_q;  // previous value, for edge detect
    logic      wr_qual;

    assign wr_qual = io_sel & io_sync & io_wr_en;

    always_ff @(posedge clk10) begin
        if (resetS) begin
            for (int f = 0; f < NUM_FUNCS; f++) begin
                for (int d = 0; d < NUM_DACS; d++) begin
                    data_regs[f][d] <= DEF_WORD[f];
                end
            end
            ctrl_go   <= 1'b1;  // arms one sequence right after reset
            ctrl_go_q <= 1'b0;
        end else begin
            ctrl_go_q <= ctrl_go;

            if (wr_qual) begin
                for (int f = 0; f < NUM_FUNCS; f++) begin
                    for (int d = 0; d < NUM_DACS; d++) begin
                        if (io_addr == reg_addr_t'(NUM_DACS * f + d))
                            data_regs[f][d] <= io_wr_data;
                    end
                end

                if (io_addr == CTRL_ADDR)
                    ctrl_go <= io_wr_data[0];  // upper control bits are not stored
            end
        end
    end

    // ========================================================================
    // read side toward the sequencer
    // ========================================================================
    always_comb begin
        for (int d = 0; d < NUM_DACS; d++) begin
            func_words[d] = data_regs[func_sel][d];
        end
    end

    // high in the cycle after bit 0 goes 0 -> 1
    assign cfg_trigger = ctrl_go & ~ctrl_go_q;

endmodule

//--- hw/dac_cfg_sequencer.sv
`timescale 1ns/10ps

module dac_cfg_sequencer import dac_cfg_pkg::*; (
    input  logic               clk10,
    input  logic               resetS,
    input  logic               cfg_trigger,
    output func_t              func_sel,
    input  dac_word_t          func_words [NUM_DACS],
    dac_frame_if.requester     frame,
    output logic               busy
);

    seq_state_t  state;
    step_t       step;        // index into the SEQ tables
    word_cnt_t   words_cur;
    frame_data_t frame_next;

    assign func_sel  = SEQ_FUNC[step];
    assign words_cur = SEQ_WORDS[step];

    // ========================================================================
    // frame assembly, DAC k-1 goes out first so it sits in the top bits
    // ========================================================================
    always_comb begin
        frame_next = '0;
        for (int i = 0; i < NUM_DACS; i++) begin
            if (i < int'(words_cur))
                frame_next[(NUM_DACS-1-i)*WORD_BITS +: WORD_BITS] =
                    func_words[int'(words_cur) - 1 - i];
        end
    end

    // payload held stable until the shifter reports done
    always_ff @(posedge clk10) begin
        if (state == SEQ_REQUEST) begin
            frame.frame_data  <= frame_next;
            frame.frame_words <= words_cur;
        end
    end

    // ========================================================================
    // step control
    // ========================================================================
    always_ff @(posedge clk10) begin
        if (resetS) begin
            state       <= SEQ_IDLE;
            step        <= '0;
            busy        <= 1'b0;
            frame.start <= 1'b0;
        end else begin
            frame.start <= 1'b0;  // single cycle pulse

            case (state)
                SEQ_IDLE: begin
                    if (cfg_trigger) begin
                        step  <= '0;
                        busy  <= 1'b1;
                        state <= SEQ_REQUEST;
                    end
                end

                SEQ_REQUEST: begin
                    frame.start <= 1'b1;
                    state       <= SEQ_WAIT_DONE;
                end

                SEQ_WAIT_DONE: begin
                    // triggers arriving here are dropped
                    if (frame.done) begin
                        if (step == step_t'(NUM_STEPS - 1)) begin
                            busy  <= 1'b0;
                            state <= SEQ_IDLE;
                        end else begin
                            step  <= step + 1'b1;
                            state <= SEQ_REQUEST;
                        end
                    end
                end

                default: state <= SEQ_IDLE;
            endcase
        end
    end

endmodule

//--- hw/dac_frame_if.sv
`timescale 1ns/10ps

// frame request channel between sequencer and serial shifter
interface dac_frame_if import dac_cfg_pkg::*; ();

    logic        start;        // one cycle request
    frame_data_t frame_data;   // left aligned, first word in top bits
    word_cnt_t   frame_words;
    logic        done;         // one cycle, after last bit and gap

    modport requester (
        output start,
        output frame_data,
        output frame_words,
        input  done
    );

    modport shifter (
        input  start,
        input  frame_data,
        input  frame_words,
        output done
    );

endinterface

//--- hw/dac_frame_shifter.sv
`timescale 1ns/10ps

module dac_frame_shifter import dac_cfg_pkg::*; (
    input  logic          clk10,
    input  logic          resetS,
    dac_frame_if.shifter  frame,
    output logic          sdi,
    output logic          sync_n
);

    shift_state_t state;
    frame_data_t  shreg;
    bit_cnt_t     bit_cnt;  // bits left after the one on sdi

    // ========================================================================
    // data path, MSB first
    // ========================================================================
    always_ff @(posedge clk10) begin
        if (state == SH_IDLE && frame.start)
            shreg <= {frame.frame_data[FRAME_BITS-2:0], 1'b0};  // top bit goes to sdi now
        else if (state == SH_SHIFT)
            shreg <= {shreg[FRAME_BITS-2:0], 1'b0};
    end

    // ========================================================================
    // frame control
    // ========================================================================
    always_ff @(posedge clk10) begin
        if (resetS) begin
            state      <= SH_IDLE;
            bit_cnt    <= '0;
            sync_n     <= 1'b1;
            sdi        <= 1'b0;
            frame.done <= 1'b0;
        end else begin
            frame.done <= 1'b0;

            case (state)
                SH_IDLE: begin
                    if (frame.start) begin
                        bit_cnt <= bit_cnt_t'(WORD_BITS * frame.frame_words - 1);
                        sdi     <= frame.frame_data[FRAME_BITS-1];
                        sync_n  <= 1'b0;  // falls on the edge after start
                        state   <= SH_SHIFT;
                    end
                end

                SH_SHIFT: begin
                    if (bit_cnt == '0) begin
                        sync_n <= 1'b1;
                        sdi    <= 1'b0;
                        state  <= SH_GAP;
                    end else begin
                        bit_cnt <= bit_cnt - 1'b1;
                        sdi     <= shreg[FRAME_BITS-1];
                    end
                end

                SH_GAP: begin
                    // sync_n high for at least this cycle before the next frame
                    frame.done <= 1'b1;
                    state      <= SH_IDLE;
                end

                default: state <= SH_IDLE;
            endcase
        end
    end

endmodule

//--- verif/afe_dac_cfg_sva.sv
`timescale 1ns/10ps

module afe_dac_cfg_sva (
    input logic clk10,
    input logic resetS,
    input logic sync_n,
    input logic busy
);

    int run_len    = 0;  // cycles of the current sync_n low run
    int violations = 0;  // read by the testbench

    always @(negedge clk10) begin
        if (sync_n === 1'b0)
            run_len <= run_len + 1;
        else
            run_len <= 0;
    end

    // ========================================================================
    // serial protocol
    // ========================================================================
    sync_high_in_reset: assert property (@(negedge clk10) resetS |-> sync_n)
        else begin
            $error("sync_n low while resetS is high");
            violations++;
        end

    // one, two or three words per frame
    frame_length: assert property (@(negedge clk10) disable iff (resetS)
        $rose(sync_n) |-> (run_len == 32 || run_len == 64 || run_len == 96))
        else begin
            $error("sync_n low run of %0d cycles", run_len);
            violations++;
        end

    busy_during_frame: assert property (@(negedge clk10) !sync_n |-> busy)
        else begin
            $error("sync_n low while busy is low");
            violations++;
        end

endmodule

bind afe_dac_cfg afe_dac_cfg_sva i_afe_dac_cfg_sva (
    .clk10  (clk10),
    .resetS (resetS),
    .sync_n (sync_n),
    .busy   (busy)
);

//--- verif/tb_afe_dac_cfg.sv
`timescale 1ns/10ps

module tb_afe_dac_cfg import dac_cfg_pkg::*; ();

    localparam int WAIT_LIMIT   = 5000;  // cycles, longer than a full sequence
    localparam int QUIET_CYCLES = 200;

    logic      clk10;
    logic      resetS;
    logic      io_sel;
    logic      io_sync;
    logic      io_wr_en;
    reg_addr_t io_addr;
    dac_word_t io_wr_data;
    logic      sclk;
    logic      sdi;
    logic      sync_n;
    logic      busy;

    dac_word_t model [NUM_FUNCS][NUM_DACS];  // expected register contents

    afe_dac_cfg i_afe_dac_cfg (.*);

    initial clk10 = 1'b0;
    always #10 clk10 = ~clk10;

    // ========================================================================
    // reporting
    // ========================================================================
    task automatic fail_run();
        $display("Simulation FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(string test_name, logic [FRAME_BITS-1:0] expected,
                               logic [FRAME_BITS-1:0] actual);
        assert (actual === expected) else begin
            $display("ERR %s expected %0h actual %0h", test_name, expected, actual);
            fail_run();
        end
    endtask

    task automatic timed_out(string what);
        $display("timeout: %s", what);
        fail_run();
    endtask

    // protocol assertions count their failures in the bound checker
    always @(negedge clk10) begin
        if (i_afe_dac_cfg.i_afe_dac_cfg_sva.violations != 0) begin
            $display("a serial protocol assertion failed");
            fail_run();
        end
    end

    // ========================================================================
    // bus and capture
    // ========================================================================
    task automatic bus_write(reg_addr_t addr, dac_word_t data, logic sel, logic sync,
                             logic wr_en);
        @(posedge clk10);
        #2;
        io_sel     = sel;
        io_sync    = sync;
        io_wr_en   = wr_en;
        io_addr    = addr;
        io_wr_data = data;
        @(posedge clk10);
        #2;
        io_sel     = 1'b0;
        io_sync    = 1'b0;
        io_wr_en   = 1'b0;
        io_addr    = '0;
        io_wr_data = '0;
    endtask

    task automatic write_reg(reg_addr_t addr, dac_word_t data);
        bus_write(addr, data, 1'b1, 1'b1, 1'b1);
    endtask

    task automatic trigger_sequence();
        write_reg(CTRL_ADDR, 32'd0);
        write_reg(CTRL_ADDR, 32'd1);  // rising edge on bit 0
    endtask

    task automatic wait_busy(logic level, string what);
        int waited;
        waited = 0;
        while (busy !== level) begin
            if (waited == WAIT_LIMIT)
                timed_out(what);
            waited++;
            @(negedge clk10);
        end
    endtask

    // bits land right aligned, first bit highest
    task automatic capture_frame(output frame_data_t bits, output int nbits);
        int waited;
        bits   = '0;
        nbits  = 0;
        waited = 0;
        while (sync_n !== 1'b0) begin
            if (waited == WAIT_LIMIT)
                timed_out("sync_n never fell for the next frame");
            waited++;
            @(negedge clk10);
        end
        while (sync_n === 1'b0) begin
            if (nbits == FRAME_BITS)
                timed_out("sync_n stayed low past a full chain frame");
            bits = {bits[FRAME_BITS-2:0], sdi};
            nbits++;
            @(negedge clk10);
        end
    endtask

    // last DAC in the chain goes out first, DAC 0 last
    function automatic frame_data_t expected_frame(func_t func, word_cnt_t nwords);
        frame_data_t f;
        f = '0;
        for (int i = int'(nwords) - 1; i >= 0; i--) begin
            f = {f[FRAME_BITS-WORD_BITS-1:0], model[int'(func)][i]};
        end
        return f;
    endfunction

    task automatic check_sequence(string test_name);
        frame_data_t got;
        int          nbits;
        for (int s = 0; s < NUM_STEPS; s++) begin
            capture_frame(got, nbits);
            check_value($sformatf("%s step %0d length", test_name, s),
                        WORD_BITS * int'(SEQ_WORDS[s]), nbits);
            check_value($sformatf("%s step %0d data", test_name, s),
                        expected_frame(SEQ_FUNC[s], SEQ_WORDS[s]), got);
        end
        wait_busy(1'b0, "busy never fell after the last frame");
    endtask

    // sclk runs on the system clock, both phases checked
    task automatic check_quiet(string test_name);
        for (int c = 0; c < QUIET_CYCLES; c++) begin
            @(posedge clk10);
            #2;
            check_value($sformatf("%s sclk high cycle %0d", test_name, c), 1, sclk);
            @(negedge clk10);
            check_value($sformatf("%s sync_n cycle %0d", test_name, c), 1, sync_n);
            #2;
            check_value($sformatf("%s sclk low cycle %0d", test_name, c), 0, sclk);
        end
    endtask

    // ========================================================================
    // test sequence
    // ========================================================================
    initial begin
        dac_word_t word;
        void'($urandom(12906));
        resetS     = 1'b1;
        io_sel     = 1'b0;
        io_sync    = 1'b0;
        io_wr_en   = 1'b0;
        io_addr    = '0;
        io_wr_data = '0;
        for (int f = 0; f < NUM_FUNCS; f++) begin
            for (int d = 0; d < NUM_DACS; d++) begin
                model[f][d] = DEF_WORD[f];
            end
        end
        repeat (8) @(posedge clk10);
        #2 resetS = 1'b0;

        check_sequence("reset_defaults");  // runs on its own after reset

        for (int f = 0; f < NUM_FUNCS; f++) begin
            for (int d = 0; d < NUM_DACS; d++) begin
                word        = $urandom;
                model[f][d] = word;
                write_reg(reg_addr_t'(NUM_DACS * f + d), word);
            end
        end
        trigger_sequence();
        check_sequence("random_words");

        bus_write(5'd5, $urandom, 1'b1, 1'b0, 1'b1);   // io_sync low
        bus_write(5'd12, $urandom, 1'b0, 1'b1, 1'b1);  // io_sel low
        bus_write(5'd7, $urandom, 1'b1, 1'b1, 1'b0);   // io_wr_en low
        write_reg(5'd23, $urandom);                    // unmapped
        trigger_sequence();
        check_sequence("dropped_writes");

        trigger_sequence();
        wait_busy(1'b1, "busy never rose after the trigger");
        trigger_sequence();  // lands while busy
        wait_busy(1'b0, "busy never fell after the sequence");
        check_quiet("trigger_while_busy");

        write_reg(CTRL_ADDR, 32'd1);  // bit 0 already set, no edge
        check_quiet("ctrl_already_set");

        if (i_afe_dac_cfg.i_afe_dac_cfg_sva.violations != 0) begin
            $display("serial protocol assertions failed during the run");
            fail_run();
        end else begin
            $display("Simulation PASSED");
            $finish;
        end
    end

endmodule

//--- verilog.f
hw/dac_cfg_pkg.sv
hw/dac_frame_if.sv
hw/dac_cfg_regs.sv
hw/dac_cfg_sequencer.sv
hw/dac_frame_shifter.sv
hw/afe_dac_cfg.sv
verif/afe_dac_cfg_sva.sv
verif/tb_afe_dac_cfg.sv
